// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - design/memStagePkg.sv
  - design/memStageIf.sv
  - design/memStageRegister.sv
  - design/dataAccessUnit.sv
  - design/writebackDriver.sv
  - design/memStage.sv
  - target: test
    files:
      - tests/memStageTb.sv

// ==== design/dataAccessUnit.sv ====
`timescale 1ns/10ps

module dataAccessUnit import memStagePkg::*;
(
	memStageIf.access access,
	accessResultIf.producer result,
	input logic dataCacheWait,
	input word_t dataBusIn,
	output word_t accessAddress,
	output word_t dataBusOut,
	output logic accessRequest,
	output logic accessWrite,
	output logic accessByte
);

	logic isLoad;
	logic isStore;
	logic isByte;
	logic useSimpleAddress;

	//////////////////////////////////////////////////
	// decode of the main operation
	//////////////////////////////////////////////////

	always_comb
	begin
		isLoad = 1'b0;
		isStore = 1'b0;
		isByte = 1'b0;
		useSimpleAddress = 1'b0;
		case (access.memOp)
			opLoadMainWord:
			begin
				isLoad = 1'b1;
			end
			opLoadMainByte:
			begin
				isLoad = 1'b1;
				isByte = 1'b1;
			end
			opLoadSimpleWord:
			begin
				isLoad = 1'b1;
				useSimpleAddress = 1'b1;
			end
			opLoadSimpleByte:
			begin
				isLoad = 1'b1;
				isByte = 1'b1;
				useSimpleAddress = 1'b1;
			end
			opStoreMainWord:
			begin
				isStore = 1'b1;
			end
			opStoreMainByte:
			begin
				isStore = 1'b1;
				isByte = 1'b1;
			end
			opStoreSimpleWord:
			begin
				isStore = 1'b1;
				useSimpleAddress = 1'b1;
			end
			opStoreSimpleByte:
			begin
				isStore = 1'b1;
				isByte = 1'b1;
				useSimpleAddress = 1'b1;
			end
			default:
			begin
				isLoad = 1'b0;
			end
		endcase
	end

	// cache request, address is zero when idle
	assign accessRequest = isLoad | isStore;
	assign accessWrite = isStore;
	assign accessByte = isByte;
	assign accessAddress = !accessRequest ? '0 :
		(useSimpleAddress ? access.simpleAluResult : access.aluResult);

	// only stores put anything on the outgoing bus
	assign dataBusOut = isStore ? access.storedValue : '0;

	// hold the instruction while the cache is busy with it
	assign result.ownCanGo = ~(accessRequest & dataCacheWait);
	assign result.loadDone = isLoad & ~dataCacheWait;

	//////////////////////////////////////////////////
	// main result
	//////////////////////////////////////////////////

	always_comb
	begin
		result.mainWriteEnable = 1'b0;
		result.mainWriteValue = '0;
		case (access.memOp)
			opMovMain:
			begin
				result.mainWriteValue = access.aluResult;
				result.mainWriteEnable = access.targetRegister != linkRegister;
			end
			opMovSimple:
			begin
				result.mainWriteValue = access.simpleAluResult;
				result.mainWriteEnable = access.targetRegister != linkRegister;
			end
			opLoadMainWord, opLoadMainByte, opLoadSimpleWord, opLoadSimpleByte:
			begin
				// data is only valid once wait has dropped
				result.mainWriteValue = dataBusIn;
				result.mainWriteEnable = ~dataCacheWait;
			end
			default:
			begin
				// stores, blanks and bubbles write nothing
				result.mainWriteEnable = 1'b0;
			end
		endcase
	end

endmodule

// ==== design/memStage.sv ====
`timescale 1ns/10ps

module memStage import memStagePkg::*;
(
	input logic clock,
	input logic reset,

	// from execute
	input logic aluValid,
	input word_t aluResult,
	input word_t simpleAluResult,
	input word_t storedValue,
	input memOp_t memOp,
	input simpleOp_t simpleOp,
	input regSelect_t targetRegister,
	input regSelect_t simpleTargetRegister,
	input logic isLoadToPc,
	input logic thumbState,

	// stall levels
	input logic wbCanGo,
	output logic memOwnCanGo,

	// data cache
	output word_t accessAddress,
	output logic accessRequest,
	output logic accessWrite,
	output logic accessByte,
	input logic dataCacheWait,
	input word_t dataBusIn,
	output word_t dataBusOut,

	// register write buses
	output word_t writeBus,
	output logic writeRegisterEnable,
	output regSelect_t writeRegisterNumber,
	output word_t thirdWriteBus,
	output logic thirdWriteRegisterEnable,
	output regSelect_t thirdWriteRegisterNumber,

	// fetch redirect
	output logic changePc,
	output word_t newPc
);

	memStageIf stageBus ();
	accessResultIf accessResult ();

	memStageRegister stageRegister
	(
		.clock(clock),
		.reset(reset),
		.aluValid(aluValid),
		.wbCanGo(wbCanGo),
		.changePc(changePc),
		.aluResult(aluResult),
		.simpleAluResult(simpleAluResult),
		.storedValue(storedValue),
		.memOp(memOp),
		.simpleOp(simpleOp),
		.targetRegister(targetRegister),
		.simpleTargetRegister(simpleTargetRegister),
		.isLoadToPc(isLoadToPc),
		.thumbState(thumbState),
		.stage(stageBus.stage),
		.result(accessResult.stall)
	);

	dataAccessUnit accessUnit
	(
		.access(stageBus.access),
		.result(accessResult.producer),
		.dataCacheWait(dataCacheWait),
		.dataBusIn(dataBusIn),
		.accessAddress(accessAddress),
		.dataBusOut(dataBusOut),
		.accessRequest(accessRequest),
		.accessWrite(accessWrite),
		.accessByte(accessByte)
	);

	// changePc also loops back to the stage register to drop the next op
	writebackDriver wbDriver
	(
		.writeback(stageBus.writeback),
		.result(accessResult.consumer),
		.writeBus(writeBus),
		.thirdWriteBus(thirdWriteBus),
		.writeRegisterEnable(writeRegisterEnable),
		.thirdWriteRegisterEnable(thirdWriteRegisterEnable),
		.writeRegisterNumber(writeRegisterNumber),
		.thirdWriteRegisterNumber(thirdWriteRegisterNumber),
		.changePc(changePc),
		.newPc(newPc)
	);

	assign memOwnCanGo = accessResult.ownCanGo;

endmodule

// ==== design/memStageIf.sv ====
`timescale 1ns/10ps

// latched instruction as seen by the rest of the stage
interface memStageIf import memStagePkg::*; ();

	memOp_t memOp;
	simpleOp_t simpleOp;
	word_t aluResult;
	word_t simpleAluResult;
	regSelect_t targetRegister;
	regSelect_t simpleTargetRegister;
	word_t storedValue;
	logic isLoadToPc;
	logic thumbState;

	modport stage
	(
		output memOp, simpleOp, aluResult, simpleAluResult, targetRegister,
		output simpleTargetRegister, storedValue, isLoadToPc, thumbState
	);

	// cache side only needs the main op, addresses and store data
	modport access
	(
		input memOp, aluResult, simpleAluResult, targetRegister, storedValue
	);

	modport writeback
	(
		input simpleOp, aluResult, simpleAluResult, targetRegister,
		input simpleTargetRegister, isLoadToPc, thumbState
	);

endinterface

// results of the data access for this cycle
interface accessResultIf import memStagePkg::*; ();

	logic mainWriteEnable;
	word_t mainWriteValue;
	logic ownCanGo;
	logic loadDone;

	modport producer (output mainWriteEnable, mainWriteValue, ownCanGo, loadDone);
	modport consumer (input mainWriteEnable, mainWriteValue, ownCanGo, loadDone);
	modport stall (input ownCanGo);

endinterface

// ==== design/memStagePkg.sv ====
package memStagePkg;

	//////////////////////////////////////////////////
	// widths fixed by the instruction set
	//////////////////////////////////////////////////

	// one data or address word
	localparam int wordWidth = 32;

	// register numbers are one nibble
	localparam int registerSelectWidth = 4;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [registerSelectWidth-1:0] regSelect_t;

	// moves aimed at the link register are not written back from here
	localparam regSelect_t linkRegister = regSelect_t'(14);

	//////////////////////////////////////////////////
	// operation encodings
	//////////////////////////////////////////////////

	// main operation of the latched instruction
	typedef enum logic [3:0]
	{
		opNull            = 4'd0,
		opMovMain         = 4'd1,
		opMovSimple       = 4'd2,
		opLoadMainWord    = 4'd3,
		opLoadMainByte    = 4'd4,
		opLoadSimpleWord  = 4'd5,
		opLoadSimpleByte  = 4'd6,
		opStoreMainWord   = 4'd7,
		opStoreMainByte   = 4'd8,
		opStoreSimpleWord = 4'd9,
		opStoreSimpleByte = 4'd10,
		opBlank           = 4'd11
	} memOp_t;

	// secondary op, only ever a move to the third bus
	typedef enum logic [1:0]
	{
		simpleNull      = 2'd0,
		simpleMovMain   = 2'd1,
		simpleMovSimple = 2'd2
	} simpleOp_t;

endpackage

// ==== design/memStageRegister.sv ====
`timescale 1ns/10ps

module memStageRegister import memStagePkg::*;
(
	input logic clock,
	input logic reset,
	input logic aluValid,
	input logic wbCanGo,
	input logic changePc,
	input word_t aluResult,
	input word_t simpleAluResult,
	input word_t storedValue,
	input memOp_t memOp,
	input simpleOp_t simpleOp,
	input regSelect_t targetRegister,
	input regSelect_t simpleTargetRegister,
	input logic isLoadToPc,
	input logic thumbState,
	memStageIf.stage stage,
	accessResultIf.stall result
);

	logic accept;
	logic take;

	memOp_t heldMemOp;
	simpleOp_t heldSimpleOp;
	logic heldIsLoadToPc;

	word_t heldAluResult;
	word_t heldSimpleAluResult;
	word_t heldStoredValue;
	regSelect_t heldTargetRegister;
	regSelect_t heldSimpleTargetRegister;
	logic heldThumbState;

	// stage advances only if writeback and the access itself can both move
	assign accept = wbCanGo & result.ownCanGo;

	// drop whatever follows a load into the pc
	assign take = accept & aluValid & ~changePc;

	//////////////////////////////////////////////////
	// control part, bubble after reset
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			heldMemOp <= opNull;
			heldSimpleOp <= simpleNull;
			heldIsLoadToPc <= 1'b0;
		end
		else if (accept)
		begin
			if (take)
			begin
				heldMemOp <= memOp;
				heldSimpleOp <= simpleOp;
				heldIsLoadToPc <= isLoadToPc;
			end
			else
			begin
				// execute had nothing, or a redirect is pending
				heldMemOp <= opNull;
				heldSimpleOp <= simpleNull;
				heldIsLoadToPc <= 1'b0;
			end
		end
	end

	// operands, only meaningful next to a live op
	always_ff @(posedge clock)
	begin
		if (take)
		begin
			heldAluResult <= aluResult;
			heldSimpleAluResult <= simpleAluResult;
			heldStoredValue <= storedValue;
			heldTargetRegister <= targetRegister;
			heldSimpleTargetRegister <= simpleTargetRegister;
			heldThumbState <= thumbState;
		end
	end

	assign stage.memOp = heldMemOp;
	assign stage.simpleOp = heldSimpleOp;
	assign stage.isLoadToPc = heldIsLoadToPc;
	assign stage.aluResult = heldAluResult;
	assign stage.simpleAluResult = heldSimpleAluResult;
	assign stage.storedValue = heldStoredValue;
	assign stage.targetRegister = heldTargetRegister;
	assign stage.simpleTargetRegister = heldSimpleTargetRegister;
	assign stage.thumbState = heldThumbState;

endmodule

// ==== design/writebackDriver.sv ====
`timescale 1ns/10ps

module writebackDriver import memStagePkg::*;
(
	memStageIf.writeback writeback,
	accessResultIf.consumer result,
	output word_t writeBus,
	output word_t thirdWriteBus,
	output logic writeRegisterEnable,
	output logic thirdWriteRegisterEnable,
	output regSelect_t writeRegisterNumber,
	output regSelect_t thirdWriteRegisterNumber,
	output logic changePc,
	output word_t newPc
);

	word_t simpleValue;
	word_t loadedWord;

	//////////////////////////////////////////////////
	// first write bus
	//////////////////////////////////////////////////

	assign writeBus = result.mainWriteValue;
	assign writeRegisterEnable = result.mainWriteEnable;
	assign writeRegisterNumber = writeback.targetRegister;

	//////////////////////////////////////////////////
	// third write bus for the simple op
	//////////////////////////////////////////////////

	always_comb
	begin
		case (writeback.simpleOp)
			simpleMovMain:
			begin
				simpleValue = writeback.aluResult;
			end
			simpleMovSimple:
			begin
				simpleValue = writeback.simpleAluResult;
			end
			default:
			begin
				simpleValue = '0;
			end
		endcase
	end

	assign thirdWriteBus = simpleValue;
	assign thirdWriteRegisterNumber = writeback.simpleTargetRegister;

	// written once, when the whole instruction leaves
	assign thirdWriteRegisterEnable = result.ownCanGo & (writeback.simpleOp != simpleNull);

	//////////////////////////////////////////////////
	// load into the pc
	//////////////////////////////////////////////////

	// the main value is the load data whenever loadDone is high
	assign loadedWord = result.mainWriteValue;

	assign changePc = result.loadDone & writeback.isLoadToPc;

	// halfword aligned, bit 1 kept only in thumb state
	assign newPc = {loadedWord[wordWidth-1:2], loadedWord[1] & writeback.thumbState, 1'b0};

endmodule

// ==== tests/memStageTb.sv ====
`timescale 1ns/10ps

module memStageTb import memStagePkg::*; ();

	localparam int instructionCount = 600;

	// 20 ns per offered instruction plus reset and drain
	localparam int watchdogLimit = instructionCount * 20 + 500;

	logic clock, reset, aluValid, wbCanGo, dataCacheWait, isLoadToPc, thumbState;
	logic memOwnCanGo, accessRequest, accessWrite, accessByte, changePc;
	logic writeRegisterEnable, thirdWriteRegisterEnable;
	word_t aluResult, simpleAluResult, storedValue, dataBusIn, dataBusOut, accessAddress;
	word_t writeBus, thirdWriteBus, newPc;
	memOp_t memOp;
	simpleOp_t simpleOp;
	regSelect_t targetRegister, simpleTargetRegister;
	regSelect_t writeRegisterNumber, thirdWriteRegisterNumber;

	// reference copy of the stage register
	memOp_t modelOp;
	simpleOp_t modelSimple;
	logic modelLoadToPc, modelThumb;
	word_t modelAlu, modelSimpleAlu, modelStored;
	regSelect_t modelTarget, modelSimpleTarget;

	// data cache model and the last store it took
	word_t cacheMem [64];
	logic storeCheck;
	logic [5:0] storeIndex;
	word_t storeValue, storedWord;

	logic [15:0] lfsrState;
	int errorCount;

	logic expLoad, expStore, expByte, expRequest, expOwnCanGo;
	logic expWriteEnable, expThirdEnable, expChangePc;
	word_t expAddress, expLoadWord, expWriteValue, expThirdValue, expNewPc, expDataOut;

	memStage dut (.*);

	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic void flagMismatch(input string name, input word_t expected,
		input word_t actual);
		errorCount++;
		$display("FAIL at %0t ns: %s expected %h got %h", $time, name, expected, actual);
	endfunction

	function automatic void noteFailure(input string what);
		errorCount++;
		$display("error at %0t ns: %s", $time, what);
	endfunction

	//////////////////////////////////////////////////
	// expected responses of the latched instruction
	//////////////////////////////////////////////////

	assign expLoad = modelOp inside {opLoadMainWord, opLoadMainByte, opLoadSimpleWord,
		opLoadSimpleByte};
	assign expStore = modelOp inside {opStoreMainWord, opStoreMainByte, opStoreSimpleWord,
		opStoreSimpleByte};
	assign expByte = modelOp inside {opLoadMainByte, opLoadSimpleByte, opStoreMainByte,
		opStoreSimpleByte};
	assign expRequest = expLoad || expStore;
	assign expAddress = (modelOp inside {opLoadSimpleWord, opLoadSimpleByte, opStoreSimpleWord,
		opStoreSimpleByte}) ? modelSimpleAlu : modelAlu;
	assign expLoadWord = cacheMem[expAddress[7:2]];
	assign expOwnCanGo = !(expRequest && dataCacheWait);
	assign expWriteEnable = (expLoad && !dataCacheWait) ||
		((modelOp == opMovMain || modelOp == opMovSimple) && modelTarget != linkRegister);
	assign expWriteValue = expLoad ? expLoadWord :
		((modelOp == opMovSimple) ? modelSimpleAlu : modelAlu);
	assign expThirdEnable = expOwnCanGo && modelSimple != simpleNull;
	assign expThirdValue = (modelSimple == simpleMovSimple) ? modelSimpleAlu : modelAlu;
	assign expChangePc = expLoad && !dataCacheWait && modelLoadToPc;
	// halfword target with bit 1 kept only in thumb state
	assign expNewPc = {expLoadWord[31:2], expLoadWord[1] & modelThumb, 1'b0};
	assign expDataOut = expStore ? modelStored : '0;

	// reads are answered once wait is low
	assign dataBusIn = (accessRequest && !accessWrite && !dataCacheWait) ?
		cacheMem[accessAddress[7:2]] : '0;
	assign storedWord = cacheMem[storeIndex];

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			modelOp <= opNull;
			modelSimple <= simpleNull;
			modelLoadToPc <= 1'b0;
			storeCheck <= 1'b0;
			// fill word depends on the whole byte address
			for (int i = 0; i < 64; i++)
			begin
				cacheMem[i] <= (i * 4) * 32'h9E3779B1 ^ 32'h00A5F00F;
			end
		end
		else
		begin
			if (wbCanGo && expOwnCanGo)
			begin
				// a redirect drops the offered instruction
				if (aluValid && !expChangePc)
				begin
					modelOp <= memOp;
					modelSimple <= simpleOp;
					modelLoadToPc <= isLoadToPc;
					modelAlu <= aluResult;
					modelSimpleAlu <= simpleAluResult;
					modelStored <= storedValue;
					modelTarget <= targetRegister;
					modelSimpleTarget <= simpleTargetRegister;
					modelThumb <= thumbState;
				end
				else
				begin
					modelOp <= opNull;
					modelSimple <= simpleNull;
					modelLoadToPc <= 1'b0;
				end
			end
			storeCheck <= expStore && !dataCacheWait;
			storeIndex <= expAddress[7:2];
			storeValue <= modelStored;
			if (accessRequest && accessWrite && !dataCacheWait)
			begin
				cacheMem[accessAddress[7:2]] <= dataBusOut;
			end
		end
	end

	initial
	begin
		logic [3:0] opCode;
		word_t mainValue;
		word_t sideValue;
		lfsrState = 16'd50;
		errorCount = 0;
		reset = 1'b0;
		{aluValid, dataCacheWait, isLoadToPc, thumbState} = 4'b0000;
		wbCanGo = 1'b1;
		memOp = opNull;
		simpleOp = simpleNull;
		{aluResult, simpleAluResult, storedValue} = '0;
		{targetRegister, simpleTargetRegister} = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b1;
		for (int n = 0; n < instructionCount; n++)
		begin
			@(posedge clock);
			opCode = 4'(randomBits(4) % 12);
			mainValue = randomBits(32);
			sideValue = randomBits(32);
			// keep addresses inside the 64 word cache
			if (opCode >= 4'd3 && opCode <= 4'd10)
			begin
				mainValue = mainValue & 32'h000000FC;
				sideValue = sideValue & 32'h000000FC;
			end
			memOp <= memOp_t'(opCode);
			simpleOp <= simpleOp_t'(2'(randomBits(2) % 3));
			aluResult <= mainValue;
			simpleAluResult <= sideValue;
			storedValue <= randomBits(32);
			targetRegister <= regSelect_t'(randomBits(4));
			simpleTargetRegister <= regSelect_t'(randomBits(4));
			isLoadToPc <= randomBits(2) == 0;
			thumbState <= randomBits(1) != 0;
			aluValid <= randomBits(2) != 0;
			wbCanGo <= randomBits(3) != 0;
			dataCacheWait <= randomBits(1) != 0;
		end
		@(posedge clock);
		aluValid <= 1'b0;
		wbCanGo <= 1'b1;
		dataCacheWait <= 1'b0;
		repeat (4) @(posedge clock);
		$display("run complete with %0d errors", errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(watchdogLimit);
		noteFailure("watchdog expired before the stimulus finished");
		$display("Result: FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// checks on the rising edge
	//////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!reset) memOwnCanGo == expOwnCanGo)
		else flagMismatch("memOwnCanGo", $sampled(expOwnCanGo), $sampled(memOwnCanGo));
	assert property (@(posedge clock) disable iff (!reset) accessRequest == expRequest)
		else flagMismatch("accessRequest", $sampled(expRequest), $sampled(accessRequest));
	assert property (@(posedge clock) disable iff (!reset)
		expRequest |-> accessAddress == expAddress)
		else flagMismatch("accessAddress", $sampled(expAddress), $sampled(accessAddress));
	assert property (@(posedge clock) disable iff (!reset) accessWrite == expStore)
		else flagMismatch("accessWrite", $sampled(expStore), $sampled(accessWrite));
	assert property (@(posedge clock) disable iff (!reset) expRequest |-> accessByte == expByte)
		else flagMismatch("accessByte", $sampled(expByte), $sampled(accessByte));
	assert property (@(posedge clock) disable iff (!reset) dataBusOut == expDataOut)
		else flagMismatch("dataBusOut", $sampled(expDataOut), $sampled(dataBusOut));
	assert property (@(posedge clock) disable iff (!reset) storeCheck |-> storedWord == storeValue)
		else flagMismatch("cacheMem", $sampled(storeValue), $sampled(storedWord));
	assert property (@(posedge clock) disable iff (!reset)
		writeRegisterEnable == expWriteEnable)
		else flagMismatch("writeRegisterEnable", $sampled(expWriteEnable),
			$sampled(writeRegisterEnable));
	assert property (@(posedge clock) disable iff (!reset)
		expWriteEnable |-> writeBus == expWriteValue)
		else flagMismatch("writeBus", $sampled(expWriteValue), $sampled(writeBus));
	assert property (@(posedge clock) disable iff (!reset)
		expWriteEnable |-> writeRegisterNumber == modelTarget)
		else flagMismatch("writeRegisterNumber", $sampled(modelTarget),
			$sampled(writeRegisterNumber));
	assert property (@(posedge clock) disable iff (!reset)
		thirdWriteRegisterEnable == expThirdEnable)
		else flagMismatch("thirdWriteRegisterEnable", $sampled(expThirdEnable),
			$sampled(thirdWriteRegisterEnable));
	assert property (@(posedge clock) disable iff (!reset)
		expThirdEnable |-> thirdWriteBus == expThirdValue)
		else flagMismatch("thirdWriteBus", $sampled(expThirdValue), $sampled(thirdWriteBus));
	assert property (@(posedge clock) disable iff (!reset)
		expThirdEnable |-> thirdWriteRegisterNumber == modelSimpleTarget)
		else flagMismatch("thirdWriteRegisterNumber", $sampled(modelSimpleTarget),
			$sampled(thirdWriteRegisterNumber));
	assert property (@(posedge clock) disable iff (!reset) changePc == expChangePc)
		else flagMismatch("changePc", $sampled(expChangePc), $sampled(changePc));
	assert property (@(posedge clock) disable iff (!reset) expChangePc |-> newPc == expNewPc)
		else flagMismatch("newPc", $sampled(expNewPc), $sampled(newPc));
	assert property (@(posedge clock) disable iff (!reset)
		(accessRequest && dataCacheWait) || !wbCanGo |=>
		$stable(accessRequest) && $stable(accessAddress) && $stable(dataBusOut))
		else noteFailure("latched access changed while the stage was stalled");
	assert property (@(posedge clock) disable iff (!reset) changePc && wbCanGo |=>
		!accessRequest && !writeRegisterEnable && !thirdWriteRegisterEnable)
		else noteFailure("instruction behind a pc load was not dropped");

endmodule

// ==== vlog.f ====
design/memStagePkg.sv
design/memStageIf.sv
design/memStageRegister.sv
design/dataAccessUnit.sv
design/writebackDriver.sv
design/memStage.sv
tests/memStageTb.sv
